// File: include/riscv_settings.svh
`ifndef RISCV_SETTINGS_SVH
`define RISCV_SETTINGS_SVH

// --------------------
// Core dimensions
// --------------------
`define RV_XLEN       32           // Data and address width
`define RV_REG_COUNT  32           // Integer registers x0..x31

// --------------------
// Reset and decode
// --------------------
`define RV_RESET_PC   32'h0000_0000 // First fetch address
`define RV_ALUCTRL_W  3            // ALU control code width

`endif

// File: src/alu.sv
`include "riscv_settings.svh"

module alu (
  input  logic [`RV_XLEN-1:0]    i_a,        // rs1
  input  logic [`RV_XLEN-1:0]    i_b,        // rs2 or immediate
  input  riscv_pkg::alu_ctrl_e   i_alu_ctrl, // Operation select
  output logic [`RV_XLEN-1:0]    o_result,
  output logic                   o_zero      // Result is zero
);

  logic slt_bit;                             // Signed compare

  assign slt_bit = $signed(i_a) < $signed(i_b);

  always_comb begin
    case (i_alu_ctrl)
      riscv_pkg::ALU_ADD: o_result = i_a + i_b;
      riscv_pkg::ALU_SUB: o_result = i_a - i_b;   // Also beq compare
      riscv_pkg::ALU_AND: o_result = i_a & i_b;
      riscv_pkg::ALU_OR:  o_result = i_a | i_b;
      riscv_pkg::ALU_SLT: o_result = {{(`RV_XLEN-1){1'b0}}, slt_bit};
      default:            o_result = '0;          // Unused codes
    endcase
  end

  assign o_zero = (o_result == '0);

endmodule

// File: src/aludec.sv
module aludec (
  input  logic                    i_opb5,     // Opcode bit 5, set for R-type
  input  logic [2:0]              i_funct3,   // funct3 field
  input  logic                    i_funct7b5, // funct7 bit 5
  input  riscv_pkg::aluop_e       i_aluop,    // Class from main decoder
  output riscv_pkg::alu_ctrl_e    o_alucrtl   // ALU control
);

  logic rtype_sub;                            // Only R-type sub subtracts

  // addi with negative immediate has bit 30 set, so opcode bit 5 must gate
  assign rtype_sub = i_opb5 & i_funct7b5;

  always_comb begin
    case (i_aluop)
      riscv_pkg::ALUOP_ADD: o_alucrtl = riscv_pkg::ALU_ADD; // lw/sw address
      riscv_pkg::ALUOP_SUB: o_alucrtl = riscv_pkg::ALU_SUB; // beq compare
      default: begin
        case (i_funct3)
          3'b000:  o_alucrtl = rtype_sub ? riscv_pkg::ALU_SUB
                                         : riscv_pkg::ALU_ADD;
          3'b010:  o_alucrtl = riscv_pkg::ALU_SLT;   // slt/slti
          3'b110:  o_alucrtl = riscv_pkg::ALU_OR;    // or/ori
          3'b111:  o_alucrtl = riscv_pkg::ALU_AND;   // and/andi
          default: o_alucrtl = riscv_pkg::ALU_ADD;   // Unsupported funct3
        endcase
      end
    endcase
  end

endmodule

// File: src/controller.sv
module controller (
  input  logic [6:0]               i_op,        // Opcode field
  input  logic [2:0]               i_funct3,    // funct3 field
  input  logic                     i_funct7b5,  // funct7 bit 5
  output riscv_pkg::alu_ctrl_e     o_alucrtl,   // ALU control
  output riscv_pkg::result_src_e   o_resultsrc, // Writeback select
  output riscv_pkg::imm_src_e      o_immsrc,    // Immediate format
  output logic                     o_memwrite,  // Store enable
  output logic                     o_alusrc,    // Immediate on ALU B
  output logic                     o_regwrite,  // Register write enable
  output logic                     o_jump,      // jal
  output logic                     o_branch     // beq, resolved in datapath
);

  riscv_pkg::aluop_e aluop;                     // Class between decoders

  // --------------------
  // Main decoder
  // --------------------
  maindec u_maindec (
    .i_op        (i_op),
    .o_resultsrc (o_resultsrc),
    .o_memwrite  (o_memwrite),
    .o_branch    (o_branch),
    .o_alusrc    (o_alusrc),
    .o_regwrite  (o_regwrite),
    .o_jump      (o_jump),
    .o_immsrc    (o_immsrc),
    .o_aluop     (aluop)
  );

  // --------------------
  // ALU decoder
  // --------------------
  aludec u_aludec (
    .i_opb5     (i_op[5]),                      // Tells R-type from I-type
    .i_funct3   (i_funct3),
    .i_funct7b5 (i_funct7b5),
    .i_aluop    (aluop),
    .o_alucrtl  (o_alucrtl)
  );

endmodule

// File: src/datapath.sv
`include "riscv_settings.svh"

module datapath (
  input  logic                     i_clk,
  input  logic                     i_reset,      // Sync, active high
  input  logic [`RV_XLEN-1:0]      i_instr,      // Current instruction
  input  logic [`RV_XLEN-1:0]      i_dmem_rdata, // Load data
  input  riscv_pkg::alu_ctrl_e     i_alu_ctrl,
  input  riscv_pkg::result_src_e   i_result_src,
  input  riscv_pkg::imm_src_e      i_imm_src,
  input  logic                     i_alu_src,    // Immediate on ALU B
  input  logic                     i_reg_write,
  input  logic                     i_jump,
  input  logic                     i_branch,
  output logic [`RV_XLEN-1:0]      o_pc,         // Fetch address
  output logic [`RV_XLEN-1:0]      o_alu_result, // Also data address
  output logic [`RV_XLEN-1:0]      o_write_data  // Store data
);

  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] pc_target;                // Branch/jump target
  logic [`RV_XLEN-1:0] pc_next;
  logic                pc_src;                   // Take target
  logic [`RV_XLEN-1:0] imm_ext;
  logic [`RV_XLEN-1:0] rd1;
  logic [`RV_XLEN-1:0] src_b;
  logic [`RV_XLEN-1:0] result;                   // Writeback value
  logic                zero;

  // --------------------
  // Program counter
  // --------------------
  assign pc_plus4  = o_pc + `RV_XLEN'd4;
  assign pc_target = o_pc + imm_ext;
  assign pc_src    = (i_branch & zero) | i_jump; // beq taken or jal
  assign pc_next   = pc_src ? pc_target : pc_plus4;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_pc <= `RV_RESET_PC;
    end else begin
      o_pc <= pc_next;
    end
  end

  // --------------------
  // Immediate extension
  // --------------------
  always_comb begin
    case (i_imm_src)
      riscv_pkg::IMM_I: imm_ext = {{(`RV_XLEN-12){i_instr[31]}}, i_instr[31:20]};
      riscv_pkg::IMM_S: imm_ext = {{(`RV_XLEN-12){i_instr[31]}}, i_instr[31:25],
                                   i_instr[11:7]};
      riscv_pkg::IMM_B: imm_ext = {{(`RV_XLEN-12){i_instr[31]}}, i_instr[7],
                                   i_instr[30:25], i_instr[11:8], 1'b0};
      default:          imm_ext = {{(`RV_XLEN-20){i_instr[31]}}, i_instr[19:12],
                                   i_instr[20], i_instr[30:21], 1'b0}; // J
    endcase
  end

  // --------------------
  // Register file and ALU
  // --------------------
  reg_file u_reg_file (
    .i_clk (i_clk),
    .i_we  (i_reg_write),
    .i_ra1 (i_instr[19:15]),                     // rs1
    .i_ra2 (i_instr[24:20]),                     // rs2
    .i_wa  (i_instr[11:7]),                      // rd
    .i_wd  (result),
    .o_rd1 (rd1),
    .o_rd2 (o_write_data)
  );

  assign src_b = i_alu_src ? imm_ext : o_write_data;

  alu u_alu (
    .i_a        (rd1),
    .i_b        (src_b),
    .i_alu_ctrl (i_alu_ctrl),
    .o_result   (o_alu_result),
    .o_zero     (zero)
  );

  // Writeback select
  always_comb begin
    case (i_result_src)
      riscv_pkg::RES_MEM: result = i_dmem_rdata;
      riscv_pkg::RES_PC4: result = pc_plus4;     // jal link
      default:            result = o_alu_result;
    endcase
  end

endmodule

// File: src/maindec.sv
module maindec (
  input  logic [6:0]               i_op,        // Opcode field
  output riscv_pkg::result_src_e   o_resultsrc, // Writeback select
  output logic                     o_memwrite,  // Store enable
  output logic                     o_branch,    // beq seen
  output logic                     o_alusrc,    // B operand is immediate
  output logic                     o_regwrite,  // Writes rd
  output logic                     o_jump,      // jal seen
  output riscv_pkg::imm_src_e      o_immsrc,    // Immediate format
  output riscv_pkg::aluop_e        o_aluop      // Class for ALU decoder
);

  always_comb begin
    // Defaults make an unknown opcode a no-op
    o_resultsrc = riscv_pkg::RES_ALU;
    o_memwrite  = 1'b0;
    o_branch    = 1'b0;
    o_alusrc    = 1'b0;
    o_regwrite  = 1'b0;
    o_jump      = 1'b0;
    o_immsrc    = riscv_pkg::IMM_I;
    o_aluop     = riscv_pkg::ALUOP_ADD;

    case (riscv_pkg::opcode_e'(i_op))
      riscv_pkg::OP_LOAD: begin
        o_regwrite  = 1'b1;
        o_alusrc    = 1'b1;               // rs1 + offset
        o_resultsrc = riscv_pkg::RES_MEM; // Load data to rd
      end
      riscv_pkg::OP_STORE: begin
        o_memwrite = 1'b1;
        o_alusrc   = 1'b1;
        o_immsrc   = riscv_pkg::IMM_S;    // Split offset
      end
      riscv_pkg::OP_RTYPE: begin
        o_regwrite = 1'b1;
        o_aluop    = riscv_pkg::ALUOP_FUNCT;
      end
      riscv_pkg::OP_ITYPE: begin
        o_regwrite = 1'b1;
        o_alusrc   = 1'b1;
        o_aluop    = riscv_pkg::ALUOP_FUNCT;
      end
      riscv_pkg::OP_BRANCH: begin
        o_branch = 1'b1;
        o_immsrc = riscv_pkg::IMM_B;
        o_aluop  = riscv_pkg::ALUOP_SUB;  // Zero flag gives equality
      end
      riscv_pkg::OP_JAL: begin
        o_regwrite  = 1'b1;
        o_jump      = 1'b1;
        o_immsrc    = riscv_pkg::IMM_J;
        o_resultsrc = riscv_pkg::RES_PC4; // Link address to rd
      end
      default: ;                          // Keep defaults
    endcase
  end

endmodule

// File: src/reg_file.sv
`include "riscv_settings.svh"

module reg_file (
  input  logic                                i_clk,
  input  logic                                i_we,  // Write enable
  input  logic [$clog2(`RV_REG_COUNT)-1:0]    i_ra1, // Read address 1
  input  logic [$clog2(`RV_REG_COUNT)-1:0]    i_ra2, // Read address 2
  input  logic [$clog2(`RV_REG_COUNT)-1:0]    i_wa,  // Write address
  input  logic [`RV_XLEN-1:0]                 i_wd,  // Write data
  output logic [`RV_XLEN-1:0]                 o_rd1, // Read data 1
  output logic [`RV_XLEN-1:0]                 o_rd2  // Read data 2
);

  logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];  // x0 entry never written

  // Write port drops writes to x0
  always_ff @(posedge i_clk) begin
    if (i_we && (i_wa != '0)) begin
      regs[i_wa] <= i_wd;
    end
  end

  // Combinational reads with x0 forced to zero
  assign o_rd1 = (i_ra1 == '0) ? '0 : regs[i_ra1];
  assign o_rd2 = (i_ra2 == '0) ? '0 : regs[i_ra2];

endmodule

// File: src/riscv_core.sv
`include "riscv_settings.svh"

module riscv_core (
  input  logic                 i_clk,
  input  logic                 i_reset,      // Sync, active high
  input  logic [`RV_XLEN-1:0]  i_imem_data,  // Fetched instruction
  input  logic [`RV_XLEN-1:0]  i_dmem_rdata, // Load data
  output logic [`RV_XLEN-1:0]  o_imem_addr,  // PC
  output logic [`RV_XLEN-1:0]  o_dmem_addr,  // ALU result
  output logic [`RV_XLEN-1:0]  o_dmem_wdata, // rs2 value
  output logic                 o_dmem_we     // Store this cycle
);

  riscv_pkg::alu_ctrl_e   alu_ctrl;
  riscv_pkg::result_src_e result_src;
  riscv_pkg::imm_src_e    imm_src;
  logic                   alu_src;
  logic                   reg_write;
  logic                   jump;
  logic                   branch;

  controller u_controller (
    .i_op        (i_imem_data[6:0]),         // Opcode
    .i_funct3    (i_imem_data[14:12]),
    .i_funct7b5  (i_imem_data[30]),
    .o_alucrtl   (alu_ctrl),
    .o_resultsrc (result_src),
    .o_immsrc    (imm_src),
    .o_memwrite  (o_dmem_we),
    .o_alusrc    (alu_src),
    .o_regwrite  (reg_write),
    .o_jump      (jump),
    .o_branch    (branch)
  );

  datapath u_datapath (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_instr      (i_imem_data),
    .i_dmem_rdata (i_dmem_rdata),
    .i_alu_ctrl   (alu_ctrl),
    .i_result_src (result_src),
    .i_imm_src    (imm_src),
    .i_alu_src    (alu_src),
    .i_reg_write  (reg_write),
    .i_jump       (jump),
    .i_branch     (branch),
    .o_pc         (o_imem_addr),
    .o_alu_result (o_dmem_addr),
    .o_write_data (o_dmem_wdata)
  );

endmodule

// File: src/riscv_pkg.sv
`include "riscv_settings.svh"

package riscv_pkg;

  // --------------------
  // Instruction opcodes
  // --------------------
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,          // lw
    OP_STORE  = 7'b0100011,          // sw
    OP_RTYPE  = 7'b0110011,          // add sub and or slt
    OP_ITYPE  = 7'b0010011,          // addi andi ori slti
    OP_BRANCH = 7'b1100011,          // beq
    OP_JAL    = 7'b1101111           // jal
  } opcode_e;

  // Operation class from main decoder
  typedef enum logic [1:0] {
    ALUOP_ADD   = 2'b00,             // Address add for lw/sw
    ALUOP_SUB   = 2'b01,             // Branch compare
    ALUOP_FUNCT = 2'b10              // Look at funct3
  } aluop_e;

  // --------------------
  // Datapath selects
  // --------------------
  typedef enum logic [`RV_ALUCTRL_W-1:0] {
    ALU_ADD = 3'b000,
    ALU_SUB = 3'b001,
    ALU_AND = 3'b010,
    ALU_OR  = 3'b011,
    ALU_SLT = 3'b101                 // Signed less-than
  } alu_ctrl_e;

  typedef enum logic [1:0] {
    IMM_I = 2'b00,                   // Loads and ALU immediates
    IMM_S = 2'b01,                   // Stores
    IMM_B = 2'b10,                   // Branch offset
    IMM_J = 2'b11                    // Jump offset
  } imm_src_e;

  typedef enum logic [1:0] {
    RES_ALU = 2'b00,                 // ALU result
    RES_MEM = 2'b01,                 // Load data
    RES_PC4 = 2'b10                  // Link address
  } result_src_e;

endpackage

// File: tb.f
+incdir+include
src/riscv_pkg.sv
src/maindec.sv
src/aludec.sv
src/controller.sv
src/reg_file.sv
src/alu.sv
src/datapath.sv
src/riscv_core.sv
testbench/riscv_core_tb.sv

// File: testbench/riscv_core_tb.sv
`include "riscv_settings.svh"

module riscv_core_tb;

  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_WORD = 3'b010;    // lw and sw
  localparam logic [6:0] F7_SUB = 7'b0100000;
  localparam int STORE_TIMEOUT = 400;         // Cycle limit for one test's stores

  logic i_clk, i_reset;
  logic [31:0] i_imem_data, i_dmem_rdata, o_imem_addr, o_dmem_addr, o_dmem_wdata;
  logic o_dmem_we;
  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] st_addr[$], st_data[$];        // Observed stores
  logic [31:0] exp_addr[$], exp_data[$];      // Expected stores
  logic [31:0] rng = 32'h24df722f;
  int slot;                                   // Next program word

  riscv_core u_dut (.i_clk(i_clk), .i_reset(i_reset), .i_imem_data(i_imem_data),
    .i_dmem_rdata(i_dmem_rdata), .o_imem_addr(o_imem_addr), .o_dmem_addr(o_dmem_addr),
    .o_dmem_wdata(o_dmem_wdata), .o_dmem_we(o_dmem_we));

  // --------------------
  // Memory models
  // --------------------
  assign i_imem_data  = imem[o_imem_addr[9:2]];
  assign i_dmem_rdata = dmem[o_dmem_addr[9:2]];

  always @(posedge i_clk) begin
    if (o_dmem_we && !i_reset) begin
      dmem[o_dmem_addr[9:2]] <= o_dmem_wdata;
      st_addr.push_back(o_dmem_addr);         // Store log
      st_data.push_back(o_dmem_wdata);
    end
  end

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // --------------------
  // Encoders
  // --------------------
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, riscv_pkg::OP_RTYPE};
  endfunction
  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction
  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1);
    return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], riscv_pkg::OP_STORE};
  endfunction
  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], riscv_pkg::OP_BRANCH};
  endfunction
  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, riscv_pkg::OP_JAL};
  endfunction
  function automatic logic [31:0] addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
    return enc_i(imm, rs1, F3_ADD, rd, riscv_pkg::OP_ITYPE);
  endfunction
  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
  endfunction

  // --------------------
  // Helpers
  // --------------------
  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      $display("Something failed");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic hold_reset();
    @(posedge i_clk);
    #1 i_reset = 1'b1;
    foreach (imem[k]) imem[k] = enc_j(21'd0, 5'd0);  // jal x0,0 parks the core
    exp_addr.delete();
    exp_data.delete();
    slot = 0;
  endtask

  task automatic emit(input logic [31:0] instr);
    imem[slot] = instr;
    slot++;
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic run_and_compare(input string name);
    int cycles;
    @(posedge i_clk);
    #1 check({name, " pc in reset"}, `RV_RESET_PC, o_imem_addr);
    @(posedge i_clk);
    #1 i_reset = 1'b0;
    st_addr.delete();
    st_data.delete();
    #3 check({name, " pc after reset"}, `RV_RESET_PC, o_imem_addr);
    cycles = 0;
    while (st_data.size() < exp_data.size()) begin
      if (cycles == STORE_TIMEOUT) begin
        $display("Timeout in %s: store %0d never arrived", name, st_data.size());
        $display("Something failed");
        $fatal(1, "Store timeout");
      end
      @(posedge i_clk);
      #1 cycles++;
    end
    foreach (exp_data[i]) begin
      check($sformatf("%s store %0d addr", name, i), exp_addr[i], st_addr[i]);
      check($sformatf("%s store %0d data", name, i), exp_data[i], st_data[i]);
    end
  endtask

  // --------------------
  // Directed tests
  // --------------------
  task automatic test_arith();
    logic [31:0] a, b;
    a = sext12(12'hff9);                      // -7
    b = 32'd300;
    hold_reset();
    emit(addi(5'd1, 5'd0, 12'hff9));
    emit(addi(5'd2, 5'd0, 12'd300));
    emit(addi(5'd4, 5'd0, 12'd256));          // Store base
    emit(enc_r(7'd0, 5'd2, 5'd1, F3_ADD, 5'd3));
    expect_store(256, a + b);
    emit(enc_s(12'd0, 5'd3, 5'd4));
    emit(enc_r(F7_SUB, 5'd2, 5'd1, F3_ADD, 5'd3));
    expect_store(260, a - b);
    emit(enc_s(12'd4, 5'd3, 5'd4));
    emit(enc_r(7'd0, 5'd2, 5'd1, F3_AND, 5'd3));
    expect_store(264, a & b);
    emit(enc_s(12'd8, 5'd3, 5'd4));
    emit(enc_r(7'd0, 5'd2, 5'd1, F3_OR, 5'd3));
    expect_store(268, a | b);
    emit(enc_s(12'd12, 5'd3, 5'd4));
    emit(enc_r(7'd0, 5'd2, 5'd1, F3_SLT, 5'd3));
    expect_store(272, {31'd0, $signed(a) < $signed(b)});
    emit(enc_s(12'd16, 5'd3, 5'd4));
    emit(enc_i(12'h0f0, 5'd1, F3_AND, 5'd3, riscv_pkg::OP_ITYPE));
    expect_store(276, a & sext12(12'h0f0));
    emit(enc_s(12'd20, 5'd3, 5'd4));
    emit(enc_i(12'hf00, 5'd2, F3_OR, 5'd3, riscv_pkg::OP_ITYPE));
    expect_store(280, b | sext12(12'hf00));
    emit(enc_s(12'd24, 5'd3, 5'd4));
    emit(enc_i(12'hffd, 5'd1, F3_SLT, 5'd3, riscv_pkg::OP_ITYPE));
    expect_store(284, {31'd0, $signed(a) < $signed(sext12(12'hffd))});
    emit(enc_s(12'd28, 5'd3, 5'd4));
    emit(addi(5'd3, 5'd1, 12'hf9c));          // Negative immediate stays an add
    expect_store(288, a + sext12(12'hf9c));
    emit(enc_s(12'd32, 5'd3, 5'd4));
    run_and_compare("arith");
  endtask

  task automatic test_load_store();
    rng = xorshift(rng);
    hold_reset();
    dmem[16] = rng;                           // Word at 0x40
    emit(addi(5'd4, 5'd0, 12'd64));
    emit(enc_i(12'd0, 5'd4, F3_WORD, 5'd5, riscv_pkg::OP_LOAD));
    emit(addi(5'd5, 5'd5, 12'hfeb));
    emit(enc_s(12'd12, 5'd5, 5'd4));
    expect_store(32'd64 + 32'd12, rng + sext12(12'hfeb));
    run_and_compare("load_store");
  endtask

  task automatic test_beq();
    int v1, v2, v3;                           // Values of x1, x2, x3
    v1 = 5;
    v2 = 5;
    v3 = 9;
    hold_reset();
    emit(addi(5'd1, 5'd0, 12'(v1)));
    emit(addi(5'd2, 5'd0, 12'(v2)));
    emit(addi(5'd3, 5'd0, 12'(v3)));
    emit(enc_b(13'd8, 5'd2, 5'd1));           // beq x1,x2 over the marker
    emit(enc_s(12'd0, 5'd1, 5'd0));           // Wrong path marker
    emit(enc_s(12'd4, 5'd3, 5'd0));
    emit(enc_b(13'd8, 5'd3, 5'd1));           // beq x1,x3
    emit(enc_s(12'd8, 5'd2, 5'd0));
    emit(enc_s(12'd12, 5'd3, 5'd0));
    if (v1 != v2) expect_store(0, v1);
    expect_store(4, v3);
    if (v1 != v3) expect_store(8, v2);
    expect_store(12, v3);
    run_and_compare("beq");
  endtask

  task automatic test_jal();
    hold_reset();
    emit(addi(5'd1, 5'd0, 12'd7));
    emit(enc_j(21'd12, 5'd5));                // At 4 with target 16
    emit(enc_s(12'd0, 5'd1, 5'd0));           // Skipped
    emit(enc_s(12'd4, 5'd1, 5'd0));           // Skipped
    emit(enc_s(12'd8, 5'd5, 5'd0));           // Link register
    emit(enc_s(12'd12, 5'd1, 5'd0));
    expect_store(8, 32'd4 + 32'd4);
    expect_store(12, 7);
    run_and_compare("jal");
  endtask

  task automatic test_random();
    logic [31:0] a, b;
    hold_reset();
    emit(addi(5'd4, 5'd0, 12'd256));          // Operand base
    emit(addi(5'd7, 5'd0, 12'd512));          // Result base
    for (int i = 0; i < 20; i++) begin
      rng = xorshift(rng);
      a = rng;
      rng = xorshift(rng);
      b = rng;
      dmem[64 + 2 * i] = a;
      dmem[65 + 2 * i] = b;
      emit(enc_i(12'(8 * i), 5'd4, F3_WORD, 5'd1, riscv_pkg::OP_LOAD));
      emit(enc_i(12'(8 * i + 4), 5'd4, F3_WORD, 5'd2, riscv_pkg::OP_LOAD));
      emit(enc_r(7'd0, 5'd2, 5'd1, F3_ADD, 5'd3));
      emit(enc_s(12'(12 * i), 5'd3, 5'd7));
      emit(enc_r(F7_SUB, 5'd2, 5'd1, F3_ADD, 5'd3));
      emit(enc_s(12'(12 * i + 4), 5'd3, 5'd7));
      emit(enc_r(7'd0, 5'd2, 5'd1, F3_SLT, 5'd3));
      emit(enc_s(12'(12 * i + 8), 5'd3, 5'd7));
      expect_store(512 + 12 * i, a + b);
      expect_store(516 + 12 * i, a - b);
      expect_store(520 + 12 * i, {31'd0, $signed(a) < $signed(b)});
    end
    run_and_compare("random");
  endtask

  initial begin
    i_reset = 1'b1;
    foreach (imem[k]) imem[k] = enc_j(21'd0, 5'd0);
    foreach (dmem[k]) dmem[k] = 32'hdead_0000 ^ (k << 2);  // Address-marked fill
    test_arith();
    test_load_store();
    test_beq();
    test_jal();
    test_random();
    $display("Everything OK");
    $finish;
  end

endmodule
